//--- source/mem_data_pkg.sv
// Shared widths, access timing and bus word layouts for the memory data path
// Memory word is two 9-bit lanes, each one data byte plus an odd parity bit
// ACCESS_CYCLES must fit in TIMER_W bits and be at least 1
package mem_data_pkg;

  localparam int BYTE_W        = 8;   // One data byte
  localparam int WORD_W        = 16;  // Local bus data width
  localparam int ACCESS_CYCLES = 3;   // Clocks per DRAM access
  localparam int TIMER_W       = 2;   // Holds ACCESS_CYCLES

  // One stored byte with its parity
  // Parity sits above the data, as on the DD bus (DD8, DD17)
  typedef struct packed {
    logic              par;   // Odd parity over data
    logic [BYTE_W-1:0] data;
  } mem_lane_t;

  // Full DRAM word, 18 bits
  typedef struct packed {
    mem_lane_t hi;  // DD17..DD9
    mem_lane_t lo;  // DD8..DD0
  } mem_word_t;

  // Status back to the CPU side
  typedef struct packed {
    logic lo_err;   // Low byte parity error, last read
    logic hi_err;   // High byte parity error, last read
    logic lerr;     // Either byte in error
    logic par_err;  // Sticky, drives the red LED
  } mem_status_t;

endpackage

//--- source/access_timer.sv
// Down-counter for the memory access time of one cycle
// expired pulses ACCESS_CYCLES edges after the edge that samples start
// A start while counting reloads and restarts the access time
`timescale 1ns/1ps

module access_timer
  import mem_data_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic start,   // Load the access time
  output logic expired  // One-cycle pulse at count zero
);

  logic [TIMER_W-1:0] cnt;  // Zero when idle

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt     <= '0;
      expired <= 1'b0;
    end else begin
      expired <= 1'b0;  // Default, pulse only
      if (start) begin
        cnt <= TIMER_W'(ACCESS_CYCLES);  // Reload, even mid count
      end else if (cnt != '0) begin
        cnt     <= cnt - TIMER_W'(1);
        expired <= (cnt == TIMER_W'(1));  // Reaching zero now
      end
    end
  end

  // Every expiry traces back to the start that loaded it
  a_expired_after_start : assert property (
    @(posedge clk) disable iff (rst)
    expired |-> $past(start, ACCESS_CYCLES + 1)
  );

endmodule

//--- source/mem_cycle_fsm.sv
// Sequences one memory cycle per req strobe: IDLE, WRITE or READ, FINISH
// write is sampled together with req and kept for the whole cycle
// req while busy is not allowed; it is ignored here
`timescale 1ns/1ps

module mem_cycle_fsm (
  input  logic clk,
  input  logic rst,
  input  logic req,          // One-cycle strobe
  input  logic write,        // Direction, valid with req
  input  logic timer_done,   // Access time over
  output logic timer_start,
  output logic busy,
  output logic done,         // One cycle, in FINISH
  output logic drive_en,     // Lanes drive toward memory
  output logic latch         // Lanes capture memory word
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    FINISH
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   wr_cyc;  // Direction of the running cycle

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_nxt = write ? WRITE : READ;
        end
      end
      WRITE, READ: begin
        if (timer_done) begin
          state_nxt = FINISH;  // Access time met
        end
      end
      FINISH:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      wr_cyc <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == IDLE && req) begin
        wr_cyc <= write;  // Held until next req
      end
    end
  end

  // Start the timer at the edge that takes the request
  assign timer_start = (state == IDLE) && req;
  assign busy        = (state != IDLE);
  assign done        = (state == FINISH);

  // Write data stays on the bus through the done cycle
  assign drive_en = (state == WRITE) || (state == FINISH && wr_cyc);
  assign latch    = (state == FINISH) && !wr_cyc;  // Read capture

  // Bus master waits for the end of busy
  a_no_req_while_busy : assert property (
    @(posedge clk) disable iff (rst)
    busy |-> !req
  );

endmodule

//--- source/parity_lane.sv
// One byte lane between the local bus and the DRAM word
// Write side is combinational and forced to zero when not driving
// err is the live odd-parity check of dd_in; the error latch samples it
`timescale 1ns/1ps

module parity_lane
  import mem_data_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [BYTE_W-1:0] wbyte,     // From local bus
  input  logic              drive_en,
  input  logic              latch,     // Capture read byte
  input  mem_lane_t         dd_in,     // From memory
  output mem_lane_t         dd_out,    // Toward memory
  output logic [BYTE_W-1:0] rbyte,     // Toward local bus
  output logic              err        // Bad parity on dd_in
);

  logic par_gen;  // Odd parity of the write byte

  // Nine bits must hold an odd count of ones
  assign par_gen = ~^wbyte;

  always_comb begin
    dd_out = '0;  // Quiet bus when not driving
    if (drive_en) begin
      dd_out.data = wbyte;
      dd_out.par  = par_gen;
    end
  end

  // Even count of ones across data and parity
  assign err = ~^dd_in;

  // Read byte held until the next read
  always_ff @(posedge clk) begin
    if (rst) begin
      rbyte <= '0;
    end else if (latch) begin
      rbyte <= dd_in.data;
    end
  end

  // Never drive and capture in the same cycle
  a_drive_latch_excl : assert property (
    @(posedge clk) disable iff (rst)
    !(drive_en && latch)
  );

endmodule

//--- source/parity_err_latch.sv
// Read error status and the sticky parity error that lights the red LED
// Lane flags update only at a read latch; par_dis blocks only the sticky flag
// Set wins over clr_err in the same cycle
`timescale 1ns/1ps

module parity_err_latch
  import mem_data_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        lo_err,   // Live check, low lane
  input  logic        hi_err,   // Live check, high lane
  input  logic        latch,    // Read capture edge
  input  logic        clr_err,  // One-cycle clear of sticky flag
  input  logic        par_dis,  // Parity disable switch
  output mem_status_t status
);

  logic lo_q;
  logic hi_q;
  logic par_q;     // LED flag
  logic par_set;

  // Any lane bad at a read, unless the switch disables it
  assign par_set = latch && (lo_err || hi_err) && !par_dis;

  always_ff @(posedge clk) begin
    if (rst) begin
      lo_q  <= 1'b0;
      hi_q  <= 1'b0;
      par_q <= 1'b0;
    end else begin
      if (latch) begin
        lo_q <= lo_err;  // Same edge as rdata
        hi_q <= hi_err;
      end
      if (par_set) begin
        par_q <= 1'b1;
      end else if (clr_err) begin
        par_q <= 1'b0;
      end
    end
  end

  assign status.lo_err  = lo_q;
  assign status.hi_err  = hi_q;
  assign status.lerr    = lo_q | hi_q;  // Combined level
  assign status.par_err = par_q;

endmodule

//--- source/mem_data_top.sv
// Memory board data path: timer, cycle FSM, two parity lanes, error latch
// Tri-state buses appear as split in and out signals, dd_oe enables dd_out
// No addressing, refresh or ECC here
`timescale 1ns/1ps

module mem_data_top
  import mem_data_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              write,
  input  logic [WORD_W-1:0] wdata,
  input  mem_word_t         dd_in,
  input  logic              clr_err,
  input  logic              par_dis,
  output logic [WORD_W-1:0] rdata,
  output logic              busy,
  output logic              done,
  output mem_word_t         dd_out,
  output logic              dd_oe,
  output mem_status_t       status
);

  logic timer_start;
  logic timer_done;
  logic drive_en;  // Also the bus enable
  logic latch;
  logic lo_err;
  logic hi_err;

  access_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .start   (timer_start),
    .expired (timer_done)
  );

  mem_cycle_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .write       (write),
    .timer_done  (timer_done),
    .timer_start (timer_start),
    .busy        (busy),
    .done        (done),
    .drive_en    (drive_en),
    .latch       (latch)
  );

  // Low byte, DD8..DD0
  parity_lane u_lane_lo (
    .clk      (clk),
    .rst      (rst),
    .wbyte    (wdata[BYTE_W-1:0]),
    .drive_en (drive_en),
    .latch    (latch),
    .dd_in    (dd_in.lo),
    .dd_out   (dd_out.lo),
    .rbyte    (rdata[BYTE_W-1:0]),
    .err      (lo_err)
  );

  // High byte, DD17..DD9
  parity_lane u_lane_hi (
    .clk      (clk),
    .rst      (rst),
    .wbyte    (wdata[WORD_W-1:BYTE_W]),
    .drive_en (drive_en),
    .latch    (latch),
    .dd_in    (dd_in.hi),
    .dd_out   (dd_out.hi),
    .rbyte    (rdata[WORD_W-1:BYTE_W]),
    .err      (hi_err)
  );

  parity_err_latch u_err (
    .clk     (clk),
    .rst     (rst),
    .lo_err  (lo_err),
    .hi_err  (hi_err),
    .latch   (latch),
    .clr_err (clr_err),
    .par_dis (par_dis),
    .status  (status)
  );

  assign dd_oe = drive_en;

endmodule

//--- test/tb_mem_data.sv
// Directed testbench for the memory board data path
// Memory side is modelled here, dd_in is set up with each read request
// Inputs change on the falling edge and outputs are sampled there as well
// Every cycle is checked for a fixed latency of ACCESS_CYCLES+1 edges
`timescale 1ns/1ps

module tb_mem_data
  import mem_data_pkg::*;
();

  localparam int CYCLE_TIMEOUT = 20;  // Edges to wait for done

  logic              clk;
  logic              rst;
  logic              req;
  logic              write;
  logic [WORD_W-1:0] wdata;
  mem_word_t         dd_in;     // Memory model output
  logic              clr_err;
  logic              par_dis;
  logic [WORD_W-1:0] rdata;
  logic              busy;
  logic              done;
  mem_word_t         dd_out;
  logic              dd_oe;
  mem_status_t       status;

  int          errors;
  int          checks;
  int          tests;
  int          test_errs;  // Error count at test start
  logic [31:0] rng;
  mem_word_t   last_bus;   // dd_out seen in the last write

  mem_data_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  function automatic int count_ones(input logic [8:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 9; i++) begin
      if (v[i]) n++;
    end
    return n;
  endfunction

  // Parity bit that makes byte plus parity hold an odd count of ones
  function automatic logic odd_par(input logic [BYTE_W-1:0] b);
    return (count_ones({1'b0, b}) % 2 == 0) ? 1'b1 : 1'b0;
  endfunction

  // Memory model word, with optional parity faults per lane
  function automatic mem_word_t encode_word(input logic [WORD_W-1:0] d,
                                            input logic flip_lo, input logic flip_hi);
    mem_word_t w;
    w.lo.data = d[BYTE_W-1:0];
    w.lo.par  = odd_par(d[BYTE_W-1:0]) ^ flip_lo;
    w.hi.data = d[WORD_W-1:BYTE_W];
    w.hi.par  = odd_par(d[WORD_W-1:BYTE_W]) ^ flip_hi;
    return w;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic verify_flags(input logic lo, input logic hi, input logic lerr,
                              input logic par);
    compare_value("status.lo_err", 32'(status.lo_err), 32'(lo));
    compare_value("status.hi_err", 32'(status.hi_err), 32'(hi));
    compare_value("status.lerr", 32'(status.lerr), 32'(lerr));
    compare_value("status.par_err", 32'(status.par_err), 32'(par));
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("%s: %0d error(s)", name, errors - test_errs);
  endtask

  // One memory cycle from req strobe to the cycle after done
  task automatic run_cycle(input logic wr, input logic [WORD_W-1:0] wd,
                           input mem_word_t din);
    int        lat;
    mem_word_t exp_bus;
    exp_bus = encode_word(wd, 1'b0, 1'b0);
    @(negedge clk);
    req   = 1'b1;
    write = wr;
    wdata = wd;
    dd_in = din;
    @(negedge clk);
    req = 1'b0;  // Edge N is behind us
    lat = 0;
    while (!done && lat < CYCLE_TIMEOUT) begin
      compare_value("busy", 32'(busy), 32'h1);
      if (wr) begin
        compare_value("dd_oe", 32'(dd_oe), 32'h1);
        compare_value("dd_out", 32'(dd_out), 32'(exp_bus));
      end else begin
        compare_value("dd_oe", 32'(dd_oe), 32'h0);  // Memory drives on a read
      end
      @(negedge clk);
      lat++;
    end
    if (!done) begin
      $display("Timeout: no done within %0d cycles of the request", CYCLE_TIMEOUT);
      errors++;
      return;
    end
    if (wr) begin
      compare_value("dd_oe", 32'(dd_oe), 32'h1);  // Still driving in done cycle
      last_bus = dd_out;
    end
    compare_value("latency", 32'(lat), 32'(ACCESS_CYCLES + 1));
    @(negedge clk);
    compare_value("done", 32'(done), 32'h0);
    compare_value("busy", 32'(busy), 32'h0);
    compare_value("dd_oe", 32'(dd_oe), 32'h0);  // Released after done
  endtask

  task automatic reset_state();
    test_errs = errors;
    compare_value("busy", 32'(busy), 32'h0);
    compare_value("done", 32'(done), 32'h0);
    compare_value("dd_oe", 32'(dd_oe), 32'h0);
    compare_value("status", 32'(status), 32'h0);
    compare_value("rdata", 32'(rdata), 32'h0);
    report_test("reset_state");
  endtask

  task automatic write_encoding();
    test_errs = errors;
    run_cycle(1'b1, 16'h5a01, '0);  // High parity 1, low parity 0
    compare_value("dd_out.lo.data", 32'(last_bus.lo.data), 32'h01);
    compare_value("dd_out.hi.data", 32'(last_bus.hi.data), 32'h5a);
    compare_value("dd_out.lo odd", 32'(count_ones(last_bus.lo) % 2), 32'h1);
    compare_value("dd_out.hi odd", 32'(count_ones(last_bus.hi) % 2), 32'h1);
    report_test("write_encoding");
  endtask

  task automatic clean_read();
    test_errs = errors;
    run_cycle(1'b0, '0, encode_word(16'hc3e7, 1'b0, 1'b0));
    compare_value("rdata", 32'(rdata), 32'hc3e7);
    verify_flags(1'b0, 1'b0, 1'b0, 1'b0);
    report_test("clean_read");
  endtask

  task automatic faulty_read();
    test_errs = errors;
    run_cycle(1'b0, '0, encode_word(16'h1234, 1'b1, 1'b0));  // Bad low lane
    compare_value("rdata", 32'(rdata), 32'h1234);
    verify_flags(1'b1, 1'b0, 1'b1, 1'b1);
    run_cycle(1'b0, '0, encode_word(16'hfe10, 1'b0, 1'b1));  // Bad high lane
    verify_flags(1'b0, 1'b1, 1'b1, 1'b1);
    run_cycle(1'b0, '0, encode_word(16'h0f0f, 1'b0, 1'b0));
    verify_flags(1'b0, 1'b0, 1'b0, 1'b1);  // LED flag stays on
    clr_err = 1'b1;
    @(negedge clk);
    clr_err = 1'b0;
    verify_flags(1'b0, 1'b0, 1'b0, 1'b0);
    report_test("faulty_read");
  endtask

  task automatic parity_disable();
    test_errs = errors;
    @(negedge clk);
    par_dis = 1'b1;
    run_cycle(1'b0, '0, encode_word(16'h8e71, 1'b0, 1'b1));
    verify_flags(1'b0, 1'b1, 1'b1, 1'b0);  // Lane still reports
    par_dis = 1'b0;
    report_test("parity_disable");
  endtask

  task automatic random_round_trips();
    logic [WORD_W-1:0] wd;
    mem_word_t         captured;
    test_errs = errors;
    for (int i = 0; i < 20; i++) begin
      rng = xorshift32(rng);
      wd  = rng[WORD_W-1:0];
      run_cycle(1'b1, wd, '0);
      captured = last_bus;
      run_cycle(1'b0, '0, captured);  // Memory returns what was written
      compare_value("rdata", 32'(rdata), 32'(wd));
      verify_flags(1'b0, 1'b0, 1'b0, 1'b0);
    end
    report_test("random_round_trips");
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_errs = 0;
    rng       = 32'hb8af_2781;
    last_bus  = '0;
    rst       = 1'b1;
    req       = 1'b0;
    write     = 1'b0;
    wdata     = '0;
    dd_in     = '0;
    clr_err   = 1'b0;
    par_dis   = 1'b0;
    repeat (5) @(posedge clk);  // Reset over 5 edges
    @(negedge clk);
    rst = 1'b0;
    reset_state();
    write_encoding();
    clean_read();
    faulty_read();
    parity_disable();
    random_round_trips();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sources.f
source/mem_data_pkg.sv
source/access_timer.sv
source/mem_cycle_fsm.sv
source/parity_lane.sv
source/parity_err_latch.sv
source/mem_data_top.sv
test/tb_mem_data.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_mem_data -o sim_mem_data
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_mem_data)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
